/* build.f */
+incdir+rtl
rtl/axis_pkg.sv
rtl/axis_register.sv
rtl/axis_pipeline_register.sv
rtl/axis_frame_tagger.sv
rtl/axis_frame_summary.sv
rtl/axis_frame_stats.sv
tests/tb_clock_gen.sv
tests/tb_axis_frame_stats.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the frame statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_axis_frame_stats \
    -f build.f -o tb_axis_frame_stats
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_axis_frame_stats > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* tests/tb_axis_frame_stats.sv */
// Frame statistics testbench

`timescale 1ns/1ps

`include "axis_macros.svh"

module tb_axis_frame_stats import axis_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;

    logic           clk;
    logic           reset;
    beat_t          s_axis_beat;
    logic           s_axis_tvalid;
    logic           s_axis_tready;
    frame_summary_t m_axis_summary;
    logic           m_axis_tvalid;
    logic           m_axis_tready;

    logic [15:0] lfsr_state;
    logic        stall_en;
    logic        timed_out;

    // Reference model state
    frame_summary_t             exp_q [$];
    logic [`AXIS_ID_WIDTH-1:0]  model_id    = '0;
    logic [`AXIS_LEN_WIDTH-1:0] model_beats = '0;
    logic [`AXIS_SUM_WIDTH-1:0] model_sum   = '0;
    int in_frames   = 0;
    int out_frames  = 0;
    int mon_errors  = 0;
    int drv_errors  = 0;
    int tests_run   = 0;
    int tests_bad   = 0;
    int errs_before = 0;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    axis_frame_stats uut (
        .clk            (clk),
        .reset          (reset),
        .s_axis_beat    (s_axis_beat),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tready  (s_axis_tready),
        .m_axis_summary (m_axis_summary),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tready  (m_axis_tready)
    );

    // Fibonacci taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic compare_summary(input frame_summary_t got, input frame_summary_t want);
        assert (got.id == want.id) else begin
            $display("ERROR: %0t m_axis_summary.id got %0d expected %0d",
                     $time, got.id, want.id);
            mon_errors++;
        end
        assert (got.beats == want.beats) else begin
            $display("ERROR: %0t m_axis_summary.beats got %0d expected %0d",
                     $time, got.beats, want.beats);
            mon_errors++;
        end
        assert (got.sum == want.sum) else begin
            $display("ERROR: %0t m_axis_summary.sum got %0h expected %0h",
                     $time, got.sum, want.sum);
            mon_errors++;
        end
    endtask

    // Mid-cycle sampling of both handshakes
    // A handshake seen here transfers on the next edge
    always @(negedge clk) begin
        frame_summary_t want;
        if (!reset && s_axis_tvalid && s_axis_tready) begin
            model_beats = model_beats + 1'b1;
            model_sum   = model_sum + `AXIS_SUM_WIDTH'(s_axis_beat.data);
            if (s_axis_beat.last) begin
                want.id    = model_id;
                want.beats = model_beats;
                want.sum   = model_sum;
                exp_q.push_back(want);
                model_id    = model_id + 1'b1;
                model_beats = '0;
                model_sum   = '0;
                in_frames++;
            end
        end
        if (!reset && m_axis_tvalid && m_axis_tready) begin
            out_frames++;
            if (exp_q.size() == 0) begin
                $display("Summary at %0t arrived with no frame left in the model", $time);
                mon_errors++;
            end else begin
                want = exp_q.pop_front();
                compare_summary(m_axis_summary, want);
            end
        end
    end

    task automatic finish_run();
        $display("Tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_bad, drv_errors + mon_errors);
        if (drv_errors + mon_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Later waits are skipped once one has run out
    task automatic report_timeout(input string what);
        $display("Timeout: %s did not finish within %0d cycles", what, WAIT_LIMIT);
        drv_errors++;
        timed_out = 1'b1;
    endtask

    task automatic end_test(input string name);
        int   total;
        logic bad;
        total = drv_errors + mon_errors;
        bad   = (total != errs_before) || timed_out;
        tests_run++;
        if (bad) begin
            tests_bad++;
        end
        $display("Test %0d %s: %s", tests_run, name, bad ? "FAIL" : "PASS");
        errs_before = total;
    endtask

    // Advance to 1 ns after the next edge and redraw the stall
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (stall_en) begin
            m_axis_tready = (rand_bits(2) != 0);
        end
    endtask

    task automatic send_beat(input logic [7:0] data, input logic last);
        int   waited;
        logic accepted;
        s_axis_beat.data = data;
        s_axis_beat.last = last;
        s_axis_tvalid    = 1'b1;
        waited           = 0;
        accepted         = 1'b0;
        while (!accepted && !timed_out && waited < WAIT_LIMIT) begin
            @(negedge clk);
            accepted = s_axis_tready;
            next_cycle();
            waited++;
        end
        s_axis_tvalid = 1'b0;
        if (!accepted && !timed_out) begin
            report_timeout("input beat handshake");
        end
    endtask

    task automatic send_frame(input int len, input logic gaps);
        for (int i = 0; i < len; i++) begin
            // Occasional idle cycles between beats
            if (gaps && rand_bits(2) == 0) begin
                repeat (1 + rand_bits(2)) next_cycle();
            end
            send_beat(8'(rand_bits(8)), i == len - 1);
        end
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !timed_out && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() == 0) begin
            // Room for a stray duplicate to show up
            repeat (5) next_cycle();
        end else if (!timed_out) begin
            report_timeout(what);
        end
    endtask

    initial begin
        int waited;
        int f0;
        int o0;
        s_axis_beat   = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        stall_en      = 1'b0;
        timed_out     = 1'b0;
        lfsr_state    = 16'd99;

        // Quiet output through reset and after it
        waited = 0;
        while (reset !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            assert (m_axis_tvalid === 1'b0) else begin
                $display("ERROR: %0t m_axis_tvalid got %b expected 0", $time, m_axis_tvalid);
                drv_errors++;
            end
            waited++;
        end
        if (reset !== 1'b0) begin
            report_timeout("reset release");
        end
        repeat (10) begin
            @(negedge clk);
            assert (m_axis_tvalid === 1'b0) else begin
                $display("ERROR: %0t m_axis_tvalid got %b expected 0", $time, m_axis_tvalid);
                drv_errors++;
            end
        end
        next_cycle();
        end_test("idle after reset");

        repeat (40) send_frame(1 + rand_bits(4), 1'b0);
        drain("random frame summaries");
        end_test("random frames");

        // Crosses the id wrap at 256
        repeat (300) send_frame(1 + rand_bits(1), 1'b0);
        drain("short frame summaries");
        end_test("frame id sequence");

        stall_en = 1'b1;
        f0       = in_frames;
        o0       = out_frames;
        repeat (40) send_frame(1 + rand_bits(4), 1'b1);
        drain("stalled frame summaries");
        stall_en      = 1'b0;
        m_axis_tready = 1'b1;
        assert (out_frames - o0 == in_frames - f0 && in_frames - f0 == 40) else begin
            $display("ERROR: %0t summary count got %0d expected %0d",
                     $time, out_frames - o0, in_frames - f0);
            drv_errors++;
        end
        end_test("back-pressure and gaps");

        repeat (30) send_beat(8'(rand_bits(8)), 1'b1);
        drain("single-beat summaries");
        end_test("single-beat frames");

        finish_run();
    end

endmodule

/* tests/tb_clock_gen.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* rtl/axis_frame_stats.sv */
// Frame statistics subsystem top

`timescale 1ns/1ps

`include "axis_macros.svh"

module axis_frame_stats import axis_pkg::*; (
    input  logic           clk,
    input  logic           reset,

    input  beat_t          s_axis_beat,
    input  logic           s_axis_tvalid,
    output logic           s_axis_tready,

    output frame_summary_t m_axis_summary,
    output logic           m_axis_tvalid,
    input  logic           m_axis_tready
);

    // Tagger to beat pipeline
    tagged_beat_t   tag_beat;
    logic           tag_valid;
    logic           tag_ready;

    // Beat pipeline to summary unit
    tagged_beat_t   pipe_beat;
    logic           pipe_valid;
    logic           pipe_ready;

    // Summary unit to summary pipeline
    frame_summary_t sum_rec;
    logic           sum_valid;
    logic           sum_ready;

    axis_frame_tagger u_tagger (
        .clk           (clk),
        .reset         (reset),
        .s_axis_beat   (s_axis_beat),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_beat   (tag_beat),
        .m_axis_tvalid (tag_valid),
        .m_axis_tready (tag_ready)
    );

    axis_pipeline_register #(
        .payload_t (tagged_beat_t),
        .REG_TYPE  (REG_SKID),
        .LENGTH    (`AXIS_BEAT_PIPE_LENGTH)
    ) u_beat_pipe (
        .clk            (clk),
        .reset          (reset),
        .s_axis_payload (tag_beat),
        .s_axis_tvalid  (tag_valid),
        .s_axis_tready  (tag_ready),
        .m_axis_payload (pipe_beat),
        .m_axis_tvalid  (pipe_valid),
        .m_axis_tready  (pipe_ready)
    );

    axis_frame_summary u_summary (
        .clk            (clk),
        .reset          (reset),
        .s_axis_beat    (pipe_beat),
        .s_axis_tvalid  (pipe_valid),
        .s_axis_tready  (pipe_ready),
        .m_axis_summary (sum_rec),
        .m_axis_tvalid  (sum_valid),
        .m_axis_tready  (sum_ready)
    );

    axis_pipeline_register #(
        .payload_t (frame_summary_t),
        .REG_TYPE  (REG_SKID),
        .LENGTH    (`AXIS_SUM_PIPE_LENGTH)
    ) u_sum_pipe (
        .clk            (clk),
        .reset          (reset),
        .s_axis_payload (sum_rec),
        .s_axis_tvalid  (sum_valid),
        .s_axis_tready  (sum_ready),
        .m_axis_payload (m_axis_summary),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tready  (m_axis_tready)
    );

endmodule

/* rtl/axis_frame_summary.sv */
// Per-frame beat count and byte sum

`timescale 1ns/1ps

`include "axis_macros.svh"

module axis_frame_summary import axis_pkg::*; (
    input  logic           clk,
    input  logic           reset,

    input  tagged_beat_t   s_axis_beat,
    input  logic           s_axis_tvalid,
    output logic           s_axis_tready,

    output frame_summary_t m_axis_summary,
    output logic           m_axis_tvalid,
    input  logic           m_axis_tready
);

    // Running totals of the open frame
    logic [`AXIS_LEN_WIDTH-1:0] beat_cnt;
    logic [`AXIS_SUM_WIDTH-1:0] byte_sum;
    logic [`AXIS_LEN_WIDTH-1:0] beat_cnt_next;
    logic [`AXIS_SUM_WIDTH-1:0] byte_sum_next;

    // Summary waiting for the consumer
    frame_summary_t summary_reg;
    logic           summary_valid;

    logic s_fire;
    logic m_fire;

    // Blocked while a summary is pending
    assign s_axis_tready = !summary_valid;
    assign s_fire        = s_axis_tvalid && s_axis_tready;
    assign m_fire        = summary_valid && m_axis_tready;

    // Totals including the current beat
    assign beat_cnt_next = beat_cnt + 1'b1;
    assign byte_sum_next = byte_sum +
        {{(`AXIS_SUM_WIDTH-`AXIS_DATA_WIDTH){1'b0}}, s_axis_beat.data};

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt      <= '0;
            byte_sum      <= '0;
            summary_valid <= 1'b0;
        end else begin
            if (m_fire) begin
                summary_valid <= 1'b0;
            end
            if (s_fire) begin
                if (s_axis_beat.last) begin
                    // Frame done so the next one starts from zero
                    summary_valid <= 1'b1;
                    beat_cnt      <= '0;
                    byte_sum      <= '0;
                end else begin
                    beat_cnt <= beat_cnt_next;
                    byte_sum <= byte_sum_next;
                end
            end
        end
    end

    // Latch the record on the last beat
    always_ff @(posedge clk) begin
        if (s_fire && s_axis_beat.last) begin
            summary_reg.id    <= s_axis_beat.id;
            summary_reg.beats <= beat_cnt_next;
            summary_reg.sum   <= byte_sum_next;
        end
    end

    assign m_axis_summary = summary_reg;
    assign m_axis_tvalid  = summary_valid;

    // Pending record is not overwritten by new input before it is taken
    a_summary_held : assert property (
        @(posedge clk) disable iff (reset)
        (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_summary))
    );

endmodule

/* rtl/axis_frame_tagger.sv */
// Frame id tagger

`timescale 1ns/1ps

`include "axis_macros.svh"

module axis_frame_tagger import axis_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  beat_t        s_axis_beat,
    input  logic         s_axis_tvalid,
    output logic         s_axis_tready,

    output tagged_beat_t m_axis_beat,
    output logic         m_axis_tvalid,
    input  logic         m_axis_tready
);

    // Id of the frame currently passing
    logic [`AXIS_ID_WIDTH-1:0] frame_id;
    logic                      last_fire;

    // Handshake passes through untouched
    assign s_axis_tready = m_axis_tready;
    assign m_axis_tvalid = s_axis_tvalid;

    assign m_axis_beat.data = s_axis_beat.data;
    assign m_axis_beat.last = s_axis_beat.last;
    assign m_axis_beat.id   = frame_id;

    // Frame closes on a transferred last beat
    assign last_fire = s_axis_tvalid && m_axis_tready && s_axis_beat.last;

    // Natural wrap at 2^8
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_id <= '0;
        end else if (last_fire) begin
            frame_id <= frame_id + 1'b1;
        end
    end

endmodule

/* rtl/axis_pipeline_register.sv */
// Chain of stream register slices

`timescale 1ns/1ps

module axis_pipeline_register import axis_pkg::*; #(
    parameter type       payload_t = logic [7:0],
    parameter reg_type_e REG_TYPE  = REG_SKID,
    // Slice count, 0 gives a pass-through
    parameter int        LENGTH    = 2
) (
    input  logic     clk,
    input  logic     reset,

    input  payload_t s_axis_payload,
    input  logic     s_axis_tvalid,
    output logic     s_axis_tready,

    output payload_t m_axis_payload,
    output logic     m_axis_tvalid,
    input  logic     m_axis_tready
);

    // Stage i feeds slice i, stage LENGTH is the output
    payload_t pipe_payload [0:LENGTH];
    logic     pipe_valid   [0:LENGTH];
    logic     pipe_ready   [0:LENGTH];

    assign pipe_payload[0]    = s_axis_payload;
    assign pipe_valid[0]      = s_axis_tvalid;
    assign s_axis_tready      = pipe_ready[0];

    assign m_axis_payload     = pipe_payload[LENGTH];
    assign m_axis_tvalid      = pipe_valid[LENGTH];
    assign pipe_ready[LENGTH] = m_axis_tready;

    for (genvar i = 0; i < LENGTH; i++) begin : g_slice
        axis_register #(
            .payload_t (payload_t),
            .REG_TYPE  (REG_TYPE)
        ) u_reg (
            .clk            (clk),
            .reset          (reset),
            .s_axis_payload (pipe_payload[i]),
            .s_axis_tvalid  (pipe_valid[i]),
            .s_axis_tready  (pipe_ready[i]),
            .m_axis_payload (pipe_payload[i+1]),
            .m_axis_tvalid  (pipe_valid[i+1]),
            .m_axis_tready  (pipe_ready[i+1])
        );
    end

endmodule

/* rtl/axis_register.sv */
// Stream register slice

`timescale 1ns/1ps

module axis_register import axis_pkg::*; #(
    parameter type       payload_t = logic [7:0],
    parameter reg_type_e REG_TYPE  = REG_SKID
) (
    input  logic     clk,
    input  logic     reset,

    input  payload_t s_axis_payload,
    input  logic     s_axis_tvalid,
    output logic     s_axis_tready,

    output payload_t m_axis_payload,
    output logic     m_axis_tvalid,
    input  logic     m_axis_tready
);

    generate
        if (REG_TYPE == REG_SKID) begin : g_skid
            // Output stage plus one spare entry behind it
            payload_t m_payload_reg;
            payload_t temp_payload_reg;
            logic     m_valid_reg;
            logic     m_valid_next;
            logic     temp_valid_reg;
            logic     temp_valid_next;
            logic     s_ready_reg;
            logic     s_ready_early;
            logic     in_to_out;
            logic     in_to_temp;
            logic     temp_to_out;

            // Ready next cycle if output drains or the spare entry stays free
            assign s_ready_early = m_axis_tready ||
                                   (!temp_valid_reg && (!m_valid_reg || !s_axis_tvalid));

            always_comb begin
                m_valid_next    = m_valid_reg;
                temp_valid_next = temp_valid_reg;
                in_to_out       = 1'b0;
                in_to_temp      = 1'b0;
                temp_to_out     = 1'b0;
                if (s_ready_reg) begin
                    if (m_axis_tready || !m_valid_reg) begin
                        // Output free or leaving, load it directly
                        m_valid_next = s_axis_tvalid;
                        in_to_out    = 1'b1;
                    end else begin
                        // Output stalled, park the beat
                        temp_valid_next = s_axis_tvalid;
                        in_to_temp      = 1'b1;
                    end
                end else if (m_axis_tready) begin
                    // Drain the spare entry into the output
                    m_valid_next    = temp_valid_reg;
                    temp_valid_next = 1'b0;
                    temp_to_out     = 1'b1;
                end
            end

            always_ff @(posedge clk) begin
                if (reset) begin
                    m_valid_reg    <= 1'b0;
                    temp_valid_reg <= 1'b0;
                    s_ready_reg    <= 1'b0;
                end else begin
                    m_valid_reg    <= m_valid_next;
                    temp_valid_reg <= temp_valid_next;
                    s_ready_reg    <= s_ready_early;
                end
            end

            // Payload path
            always_ff @(posedge clk) begin
                if (in_to_out) begin
                    m_payload_reg <= s_axis_payload;
                end else if (temp_to_out) begin
                    m_payload_reg <= temp_payload_reg;
                end
                if (in_to_temp) begin
                    temp_payload_reg <= s_axis_payload;
                end
            end

            assign s_axis_tready  = s_ready_reg;
            assign m_axis_payload = m_payload_reg;
            assign m_axis_tvalid  = m_valid_reg;
        end else if (REG_TYPE == REG_SIMPLE) begin : g_simple
            payload_t m_payload_reg;
            logic     m_valid_reg;

            // Take a beat only when the single stage is empty or draining
            assign s_axis_tready = !m_valid_reg || m_axis_tready;

            always_ff @(posedge clk) begin
                if (reset) begin
                    m_valid_reg <= 1'b0;
                end else if (s_axis_tready) begin
                    m_valid_reg <= s_axis_tvalid;
                end
            end

            always_ff @(posedge clk) begin
                if (s_axis_tready && s_axis_tvalid) begin
                    m_payload_reg <= s_axis_payload;
                end
            end

            assign m_axis_payload = m_payload_reg;
            assign m_axis_tvalid  = m_valid_reg;
        end else begin : g_bypass
            // Straight wires
            assign s_axis_tready  = m_axis_tready;
            assign m_axis_payload = s_axis_payload;
            assign m_axis_tvalid  = s_axis_tvalid;
        end
    endgenerate

    // Stalled output holds its beat until taken
    a_hold_stalled : assert property (
        @(posedge clk) disable iff (reset)
        (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_payload))
    );

endmodule

/* rtl/axis_pkg.sv */
// Frame statistics stream types

`include "axis_macros.svh"

package axis_pkg;

    // Raw input beat, 9 bits
    typedef struct packed {
        logic [`AXIS_DATA_WIDTH-1:0] data;
        logic                        last;
    } beat_t;

    // Beat with its frame id attached, 17 bits
    typedef struct packed {
        logic [`AXIS_DATA_WIDTH-1:0] data;
        logic                        last;
        logic [`AXIS_ID_WIDTH-1:0]   id;
    } tagged_beat_t;

    // One record per frame, 36 bits
    typedef struct packed {
        logic [`AXIS_ID_WIDTH-1:0]  id;
        logic [`AXIS_LEN_WIDTH-1:0] beats;
        logic [`AXIS_SUM_WIDTH-1:0] sum;
    } frame_summary_t;

    // Register slice mode
    typedef enum logic [1:0] {
        REG_BYPASS = 2'd0,
        REG_SIMPLE = 2'd1,
        REG_SKID   = 2'd2
    } reg_type_e;

endpackage

/* rtl/axis_macros.svh */
// Stream widths and pipeline depths

`ifndef AXIS_MACROS_SVH
`define AXIS_MACROS_SVH

// Beat data width
`define AXIS_DATA_WIDTH 8

// Frame id width, wraps at 2^8
`define AXIS_ID_WIDTH 8

// Beat count per frame
`define AXIS_LEN_WIDTH 12

// Byte sum, modulo 2^16
`define AXIS_SUM_WIDTH 16

// Register slices on the beat path
`define AXIS_BEAT_PIPE_LENGTH 2

// Register slices on the summary path
`define AXIS_SUM_PIPE_LENGTH 1

`endif
